// File: mpmc_macros.svh
`ifndef MPMC_MACROS_SVH
`define MPMC_MACROS_SVH

// ==================================================
// Application interface widths
// ==================================================

// Native address width of the memory-interface core
`define MPMC_ADDR_W 28
// One full DDR3 burst word, always written without byte masks
`define MPMC_DATA_W 128
// Width of the app_cmd field
`define MPMC_CMD_W 3

// ==================================================
// Application command codes
// ==================================================
`define MPMC_CMD_WRITE 3'b000
`define MPMC_CMD_READ 3'b001

`endif

// File: mpmc_pkg.sv
`include "mpmc_macros.svh"

package mpmc_pkg;

	// ==================================================
	// Vector types
	// ==================================================

	// Address as seen on app_addr
	typedef logic [`MPMC_ADDR_W-1:0] app_addr_t;

	// Data word on both the write FIFO and the read return
	typedef logic [`MPMC_DATA_W-1:0] app_data_t;

	// Command code driven on app_cmd
	typedef logic [`MPMC_CMD_W-1:0] app_cmd_t;

	// Index of a client port, only two ports exist
	typedef logic port_sel_t;

	// ==================================================
	// Request bundle
	// ==================================================

	// One client request, held stable by the client while req is high
	// The write flag sits on top so that a dump reads we, addr, wdata
	typedef struct packed {
		logic we;
		app_addr_t addr;
		app_data_t wdata;
	} port_req_t;

	// ==================================================
	// Controller state
	// ==================================================

	// Two preset states give the arbiter and the request register time
	// to settle before the command code is chosen
	typedef enum logic [2:0] {
		idle,
		preset1,
		preset2,
		write_data,
		issue_cmd,
		wait_rd,
		wait_nack
	} mpmc_state_t;

endpackage

// File: mpmc_port_arbiter.sv
`timescale 1ns/1ps

module mpmc_port_arbiter (
	input logic clk,
	input logic rst,
	input logic [1:0] req,
	input mpmc_pkg::port_req_t req_data0,
	input mpmc_pkg::port_req_t req_data1,
	input logic take,
	output mpmc_pkg::port_sel_t grant,
	output mpmc_pkg::port_req_t gnt_req
);
	import mpmc_pkg::*;

	// Port that wins when both ports request in the same cycle
	port_sel_t prio;
	// Port chosen in the current cycle, only meaningful while take is high
	port_sel_t pick;

	// A lone request always wins
	// With both ports requesting, the tie goes to the priority port
	always_comb begin
		case (req)
			2'b01: pick = 1'b0;
			2'b10: pick = 1'b1;
			2'b11: pick = prio;
			default: pick = grant;
		endcase
	end

	// Grant and priority are control state and start from port 0
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= 1'b0;
			prio <= 1'b0;
		end else if (take) begin
			grant <= pick;
			// The port just served drops to the back of the line
			prio <= ~pick;
		end
	end

	// The chosen request is a payload copy held until the next take
	always_ff @(posedge clk) begin
		if (take) begin
			gnt_req <= pick ? req_data1 : req_data0;
		end
	end

endmodule

// File: mpmc_app_cmd_gen.sv
`timescale 1ns/1ps
`include "mpmc_macros.svh"

module mpmc_app_cmd_gen (
	input logic clk,
	input logic rst,
	input mpmc_pkg::mpmc_state_t state,
	input logic wr,
	output mpmc_pkg::app_cmd_t cmd
);
	import mpmc_pkg::*;

	// The core expects write as the resting command code
	// Read is only selected once the request type is known in preset2
	// Every state that changes the code has app_en low, so the code
	// is stable for the whole time a command is offered to the core
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd <= `MPMC_CMD_WRITE;
		end else begin
			case (state)
				idle: cmd <= `MPMC_CMD_WRITE;
				preset2: begin
					if (wr) begin
						cmd <= `MPMC_CMD_WRITE;
					end else begin
						cmd <= `MPMC_CMD_READ;
					end
				end
				// Back to the default once the command has completed
				wait_nack: cmd <= `MPMC_CMD_WRITE;
				default: cmd <= cmd;
			endcase
		end
	end

endmodule

// File: mpmc_fsm.sv
`timescale 1ns/1ps

module mpmc_fsm (
	input logic clk,
	input logic rst,
	input logic [1:0] req,
	input mpmc_pkg::port_sel_t grant,
	input logic wr,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	output mpmc_pkg::mpmc_state_t state,
	output logic take,
	output logic latch,
	output logic done,
	output logic rd_capture,
	output logic app_en,
	output logic app_wdf_wren,
	output logic app_wdf_end
);
	import mpmc_pkg::*;

	mpmc_state_t state_nxt;

	// ==================================================
	// Next state
	// ==================================================

	// Every wait state loops on itself, so back-pressure simply freezes
	// the machine and the registered strobes stay where they are
	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (|req) begin
					state_nxt = preset1;
				end
			end
			// Arbiter result becomes valid here
			preset1: state_nxt = preset2;
			// Request register is loaded, wr is now valid
			preset2: begin
				if (wr) begin
					state_nxt = write_data;
				end else begin
					state_nxt = issue_cmd;
				end
			end
			// Write data goes into the FIFO ahead of the command
			write_data: begin
				if (app_wdf_rdy) begin
					state_nxt = issue_cmd;
				end
			end
			issue_cmd: begin
				if (app_rdy) begin
					state_nxt = wr ? wait_nack : wait_rd;
				end
			end
			wait_rd: begin
				if (app_rd_data_valid) begin
					state_nxt = wait_nack;
				end
			end
			// Wait for the served client to drop its request
			wait_nack: begin
				if (!req[grant]) begin
					state_nxt = idle;
				end
			end
			default: state_nxt = idle;
		endcase
	end

	// ==================================================
	// Pulses to the arbiter and data path
	// ==================================================
	assign take = (state == idle) && (|req);
	assign latch = (state == preset1);
	assign rd_capture = (state == wait_rd) && app_rd_data_valid;

	// Raised on the edge into wait_nack, so the registered ack lands in
	// the first wait_nack cycle together with the captured read word
	assign done = ((state == issue_cmd) && app_rdy && wr) || rd_capture;

	// ==================================================
	// State and memory-side strobes
	// ==================================================

	// Strobes are decoded from the next state and registered so they
	// come straight out of flops and sit low after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			app_en <= 1'b0;
			app_wdf_wren <= 1'b0;
		end else begin
			state <= state_nxt;
			app_en <= (state_nxt == issue_cmd);
			app_wdf_wren <= (state_nxt == write_data);
		end
	end

	// Single-beat writes, every beat is also the last of its burst
	assign app_wdf_end = app_wdf_wren;

endmodule

// File: mpmc_data_path.sv
`timescale 1ns/1ps

module mpmc_data_path (
	input logic clk,
	input logic rst,
	input logic latch,
	input logic rd_capture,
	input logic done,
	input mpmc_pkg::port_sel_t grant,
	input mpmc_pkg::port_req_t gnt_req,
	input mpmc_pkg::app_data_t app_rd_data,
	output mpmc_pkg::app_addr_t app_addr,
	output mpmc_pkg::app_data_t app_wdf_data,
	output logic wr,
	output logic [1:0] ack,
	output mpmc_pkg::app_data_t rdata0,
	output mpmc_pkg::app_data_t rdata1
);
	import mpmc_pkg::*;

	// Working copy of the request being served
	port_req_t cur_req;

	// ==================================================
	// Request register
	// ==================================================

	// Loaded once per transaction in preset1
	// The client fields need not stay stable after this point
	always_ff @(posedge clk) begin
		if (latch) begin
			cur_req <= gnt_req;
		end
	end

	assign wr = cur_req.we;
	assign app_addr = cur_req.addr;
	assign app_wdf_data = cur_req.wdata;

	// ==================================================
	// Read return
	// ==================================================

	// Each port keeps its last read word until its next read
	always_ff @(posedge clk) begin
		if (rd_capture && (grant == 1'b0)) begin
			rdata0 <= app_rd_data;
		end
		if (rd_capture && (grant == 1'b1)) begin
			rdata1 <= app_rd_data;
		end
	end

	// ==================================================
	// Acknowledge steering
	// ==================================================

	// One-cycle pulse on the port that owns the current transaction
	// The grant is held by the arbiter until the next take, which cannot
	// happen before the machine has passed through wait_nack
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 2'b00;
		end else if (done) begin
			ack <= grant ? 2'b10 : 2'b01;
		end else begin
			ack <= 2'b00;
		end
	end

endmodule

// File: mpmc_top.sv
`timescale 1ns/1ps

module mpmc_top (
	input logic clk,
	input logic rst,
	// Client ports
	input logic [1:0] req,
	input mpmc_pkg::port_req_t req_data0,
	input mpmc_pkg::port_req_t req_data1,
	output logic [1:0] ack,
	output mpmc_pkg::app_data_t rdata0,
	output mpmc_pkg::app_data_t rdata1,
	// Command channel of the memory-interface core
	output logic app_en,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::app_addr_t app_addr,
	input logic app_rdy,
	// Write-data FIFO
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output mpmc_pkg::app_data_t app_wdf_data,
	input logic app_wdf_rdy,
	// Read return
	input mpmc_pkg::app_data_t app_rd_data,
	input logic app_rd_data_valid
);
	import mpmc_pkg::*;

	// Arbiter result, held for the whole transaction
	port_sel_t grant;
	port_req_t gnt_req;

	mpmc_state_t state;
	logic take;
	logic latch;
	logic done;
	logic rd_capture;
	// Request type from the data path's request register
	logic wr;

	mpmc_port_arbiter i_arbiter (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data0(req_data0),
		.req_data1(req_data1),
		.take(take),
		.grant(grant),
		.gnt_req(gnt_req)
	);

	mpmc_fsm i_fsm (
		.clk(clk),
		.rst(rst),
		.req(req),
		.grant(grant),
		.wr(wr),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.state(state),
		.take(take),
		.latch(latch),
		.done(done),
		.rd_capture(rd_capture),
		.app_en(app_en),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end)
	);

	mpmc_app_cmd_gen i_cmd_gen (
		.clk(clk),
		.rst(rst),
		.state(state),
		.wr(wr),
		.cmd(app_cmd)
	);

	mpmc_data_path i_data_path (
		.clk(clk),
		.rst(rst),
		.latch(latch),
		.rd_capture(rd_capture),
		.done(done),
		.grant(grant),
		.gnt_req(gnt_req),
		.app_rd_data(app_rd_data),
		.app_addr(app_addr),
		.app_wdf_data(app_wdf_data),
		.wr(wr),
		.ack(ack),
		.rdata0(rdata0),
		.rdata1(rdata1)
	);

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	// Free-running clock with an 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Reset is high from time zero and drops after the fifth rising edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: tb_app_mem_model.sv
`timescale 1ns/1ps
`include "mpmc_macros.svh"

module tb_app_mem_model (
	input logic clk,
	input logic rst,
	input logic app_en,
	input mpmc_pkg::app_cmd_t app_cmd,
	input mpmc_pkg::app_addr_t app_addr,
	output logic app_rdy,
	input logic app_wdf_wren,
	input logic app_wdf_end,
	input mpmc_pkg::app_data_t app_wdf_data,
	output logic app_wdf_rdy,
	output mpmc_pkg::app_data_t app_rd_data,
	output logic app_rd_data_valid
);
	import mpmc_pkg::*;

	integer seed;
	// Sparse DDR3 contents, an address never written reads as zero
	app_data_t mem [app_addr_t];
	// Word taken from the write-data FIFO, waiting for its command
	app_data_t wdf_word;
	logic wdf_full;
	// Outstanding read and the cycles left until its data returns
	logic rd_busy;
	app_addr_t rd_addr;
	int rd_wait;

	initial begin
		seed = 32'hb9ad;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
	end

	always @(posedge clk) begin
		if (rst) begin
			app_rdy <= 1'b0;
			app_wdf_rdy <= 1'b0;
			app_rd_data <= '0;
			app_rd_data_valid <= 1'b0;
			wdf_full <= 1'b0;
			rd_busy <= 1'b0;
			rd_wait <= 0;
		end else begin
			// Each ready level drops about one cycle in four
			app_rdy <= (($random(seed) & 3) != 0);
			app_wdf_rdy <= (($random(seed) & 3) != 0);
			app_rd_data_valid <= 1'b0;

			// Write data is accepted on its own handshake
			if (app_wdf_wren && app_wdf_rdy && app_wdf_end) begin
				wdf_word <= app_wdf_data;
				wdf_full <= 1'b1;
			end

			// A command completes in a cycle with app_rdy high
			if (app_en && app_rdy) begin
				if (app_cmd == `MPMC_CMD_READ) begin
					rd_busy <= 1'b1;
					rd_addr <= app_addr;
					rd_wait <= 2 + ($random(seed) & 7);
				end else if (wdf_full) begin
					// Only stored once both halves of the write have arrived
					mem[app_addr] = wdf_word;
					wdf_full <= 1'b0;
				end
			end

			// Read return is a single-cycle strobe after 2 to 9 cycles
			if (rd_busy) begin
				if (rd_wait <= 1) begin
					app_rd_data_valid <= 1'b1;
					app_rd_data <= mem.exists(rd_addr) ? mem[rd_addr] : '0;
					rd_busy <= 1'b0;
				end else begin
					rd_wait <= rd_wait - 1;
				end
			end
		end
	end

endmodule

// File: tb_mpmc_top.sv
`timescale 1ns/1ps
`include "mpmc_macros.svh"

module tb_mpmc_top;
	import mpmc_pkg::*;

	localparam int ACK_TIMEOUT = 200;
	localparam int RST_TIMEOUT = 20;
	localparam string STIM_FILE = "mpmc_stimulus.txt";

	logic clk;
	logic rst;
	logic [1:0] req;
	port_req_t req_data0;
	port_req_t req_data1;
	logic [1:0] ack;
	app_data_t rdata0;
	app_data_t rdata1;
	logic app_en;
	app_cmd_t app_cmd;
	app_addr_t app_addr;
	logic app_rdy;
	logic app_wdf_wren;
	logic app_wdf_end;
	app_data_t app_wdf_data;
	logic app_wdf_rdy;
	app_data_t app_rd_data;
	logic app_rd_data_valid;

	// Transaction list with one entry per stimulus line and per final read-back
	bit pair_q[$];
	port_sel_t port_q[$];
	port_req_t req_q[$];
	app_data_t exp_q[$];
	string name_q[$];
	// Last word the file writes to each address
	app_data_t shadow [app_addr_t];

	// Round-robin record kept by the testbench
	logic served_any;
	port_sel_t last_served;
	// Command the monitor expects on the next rising edge of app_en
	app_cmd_t exp_cmd;
	app_cmd_t held_cmd;
	logic en_seen;
	int idx;

	tb_clk_gen i_clk_gen (
		.clk(clk),
		.rst(rst)
	);

	mpmc_top i_dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data0(req_data0),
		.req_data1(req_data1),
		.ack(ack),
		.rdata0(rdata0),
		.rdata1(rdata1),
		.app_en(app_en),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_wdf_data(app_wdf_data),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

	tb_app_mem_model i_mem (
		.clk(clk),
		.rst(rst),
		.app_en(app_en),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_wdf_data(app_wdf_data),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

	// ==================================================
	// Error handling and compare tasks
	// ==================================================

	task automatic stop_on_error();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR %s", msg);
		stop_on_error();
	endtask

	task automatic check_data(input string name, input app_data_t exp, input app_data_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_cmd(input string name, input app_cmd_t exp, input app_cmd_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_port(input string name, input port_sel_t exp, input port_sel_t act);
		if (act !== exp) begin
			$display("FAIL %s expected port %0d actual port %0d", name, exp, act);
			stop_on_error();
		end
	endtask

	// Single control bits such as strobes and acknowledges
	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected %b actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	// Write requests expect the write code and reads expect the read code
	function automatic app_cmd_t cmd_for(input logic we);
		return we ? `MPMC_CMD_WRITE : `MPMC_CMD_READ;
	endfunction

	// ==================================================
	// Stimulus file
	// ==================================================

	task automatic load_stimulus();
		int fd;
		int cnt;
		int line_no;
		string line;
		logic [31:0] pair_f;
		logic [31:0] port_f;
		logic [31:0] we_f;
		app_addr_t addr_f;
		app_data_t wdata_f;
		app_data_t exp_f;
		port_req_t r;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			report_problem("the stimulus file could not be opened");
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			line_no++;
			if ((cnt == 0) || (line.len() == 0) || (line[0] == "#")) begin
				continue;
			end
			cnt = $sscanf(line, "%h %h %h %h %h %h", pair_f, port_f, we_f, addr_f, wdata_f,
				exp_f);
			// Blank lines scan as nothing and are skipped
			if (cnt <= 0) begin
				continue;
			end
			if (cnt != 6) begin
				report_problem($sformatf("stimulus line %0d is missing columns", line_no));
			end
			r.we = we_f[0];
			r.addr = addr_f;
			r.wdata = wdata_f;
			pair_q.push_back(pair_f[0]);
			port_q.push_back(port_f[0]);
			req_q.push_back(r);
			exp_q.push_back(exp_f);
			name_q.push_back($sformatf("line%0d", line_no));
			if (r.we) begin
				shadow[r.addr] = r.wdata;
			end
		end
		$fclose(fd);
		if (req_q.size() == 0) begin
			report_problem("the stimulus file holds no transactions");
		end
	endtask

	// Every written address is read back on port 0 after the file is done
	task automatic queue_readback();
		app_addr_t a;
		port_req_t r;
		if (shadow.first(a)) begin
			do begin
				r.we = 1'b0;
				r.addr = a;
				r.wdata = '0;
				pair_q.push_back(1'b0);
				port_q.push_back(1'b0);
				req_q.push_back(r);
				exp_q.push_back(shadow[a]);
				name_q.push_back($sformatf("readback_%h", a));
			end while (shadow.next(a));
		end
	endtask

	// ==================================================
	// Client port driving
	// ==================================================

	// Called right after a rising edge so the request lands on that edge
	task automatic drive_req(input port_sel_t p, input port_req_t r);
		if (p) begin
			req_data1 <= r;
		end else begin
			req_data0 <= r;
		end
		req[p] <= 1'b1;
	endtask

	// Acks are sampled on the falling edge where they are settled
	task automatic wait_ack(input string name, output port_sel_t p);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while ((ack == 2'b00) && (cycles < ACK_TIMEOUT)) begin
			@(negedge clk);
			cycles++;
		end
		if (ack == 2'b00) begin
			report_problem($sformatf("%s got no acknowledge within %0d cycles", name,
				ACK_TIMEOUT));
		end
		if (ack == 2'b11) begin
			report_problem($sformatf("%s saw both ports acknowledged together", name));
		end
		p = ack[1];
	endtask

	// Check the read word in the ack cycle and drop req on the next edge
	task automatic close_txn(input int i);
		port_sel_t p;
		p = port_q[i];
		if (!req_q[i].we) begin
			check_data(name_q[i], exp_q[i], p ? rdata1 : rdata0);
		end
		last_served = p;
		served_any = 1'b1;
		@(posedge clk);
		req[p] <= 1'b0;
	endtask

	task automatic run_single(input int i);
		port_sel_t p;
		@(posedge clk);
		exp_cmd = cmd_for(req_q[i].we);
		drive_req(port_q[i], req_q[i]);
		wait_ack(name_q[i], p);
		check_port({name_q[i], "_ack"}, port_q[i], p);
		close_txn(i);
	endtask

	// Both requests rise together and the winner follows the round-robin rule
	task automatic run_pair(input int i, input int j);
		port_sel_t first;
		port_sel_t p;
		int fi;
		int si;
		if ((j >= req_q.size()) || (port_q[i] == port_q[j])) begin
			report_problem($sformatf("%s has no partner on the other port", name_q[i]));
		end
		first = served_any ? ~last_served : 1'b0;
		fi = (port_q[i] == first) ? i : j;
		si = (fi == i) ? j : i;
		@(posedge clk);
		exp_cmd = cmd_for(req_q[fi].we);
		drive_req(port_q[i], req_q[i]);
		drive_req(port_q[j], req_q[j]);
		wait_ack(name_q[fi], p);
		check_port({name_q[fi], "_first"}, first, p);
		close_txn(fi);
		exp_cmd = cmd_for(req_q[si].we);
		wait_ack(name_q[si], p);
		check_port({name_q[si], "_second"}, ~first, p);
		close_txn(si);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while ((rst !== 1'b0) && (cycles < RST_TIMEOUT)) begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			report_problem("reset was never released");
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_flag("reset_app_en", 1'b0, app_en);
		check_flag("reset_app_wdf_wren", 1'b0, app_wdf_wren);
		check_flag("reset_ack0", 1'b0, ack[0]);
		check_flag("reset_ack1", 1'b0, ack[1]);
		check_cmd("reset_app_cmd", `MPMC_CMD_WRITE, app_cmd);
	endtask

	// ==================================================
	// Command monitor
	// ==================================================

	// The code is checked on the first app_en cycle and must then hold
	always @(negedge clk) begin
		if (rst) begin
			en_seen = 1'b0;
		end else begin
			if (app_en && !en_seen) begin
				held_cmd = app_cmd;
				check_cmd("cmd_type", exp_cmd, app_cmd);
			end else if (app_en) begin
				check_cmd("cmd_stable", held_cmd, app_cmd);
			end
			en_seen = app_en;
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		req = 2'b00;
		req_data0 = '0;
		req_data1 = '0;
		served_any = 1'b0;
		last_served = 1'b0;
		exp_cmd = `MPMC_CMD_WRITE;
		held_cmd = `MPMC_CMD_WRITE;
		en_seen = 1'b0;
		load_stimulus();
		queue_readback();
		wait_reset_release();
		check_reset_state();
		idx = 0;
		while (idx < req_q.size()) begin
			if (pair_q[idx]) begin
				run_pair(idx, idx + 1);
				idx += 2;
			end else begin
				run_single(idx);
				idx += 1;
			end
		end
		repeat (4) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: mpmc_top.f
+incdir+.
mpmc_pkg.sv
mpmc_port_arbiter.sv
mpmc_app_cmd_gen.sv
mpmc_fsm.sv
mpmc_data_path.sv
mpmc_top.sv
tb_clk_gen.sv
tb_app_mem_model.sv
tb_mpmc_top.sv

// File: mpmc_stimulus.txt
# pair port we addr wdata expected_rdata (hex), pair=1 issues this line with the next one
# expected_rdata is the last word written to addr, zero if never written, ignored for writes
0 0 1 0000100 0123456789abcdef0011223344556677 00000000000000000000000000000000
0 0 0 0000100 00000000000000000000000000000000 0123456789abcdef0011223344556677
0 1 0 0000200 00000000000000000000000000000000 00000000000000000000000000000000
0 1 1 0000200 fedcba98765432108899aabbccddeeff 00000000000000000000000000000000
0 1 0 0000200 00000000000000000000000000000000 fedcba98765432108899aabbccddeeff
1 0 1 0000300 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 00000000000000000000000000000000
0 1 1 0001000 00000001000000020000000300000004 00000000000000000000000000000000
1 0 0 0000300 00000000000000000000000000000000 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
0 1 0 0001000 00000000000000000000000000000000 00000001000000020000000300000004
0 0 1 0000100 deadbeefcafef00d1234567890abcdef 00000000000000000000000000000000
0 1 0 0000100 00000000000000000000000000000000 deadbeefcafef00d1234567890abcdef
1 1 1 0fffff0 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000
0 0 1 0000040 80000000000000000000000000000001 00000000000000000000000000000000
1 0 0 0fffff0 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff
0 1 0 0000040 00000000000000000000000000000000 80000000000000000000000000000001
0 0 1 0000200 13579bdf2468ace013579bdf2468ace0 00000000000000000000000000000000
0 0 0 0000200 00000000000000000000000000000000 13579bdf2468ace013579bdf2468ace0
1 0 1 0001000 0badc0de0badc0de0badc0de0badc0de 00000000000000000000000000000000
0 1 0 0000100 00000000000000000000000000000000 deadbeefcafef00d1234567890abcdef
0 1 0 0001000 00000000000000000000000000000000 0badc0de0badc0de0badc0de0badc0de
0 0 1 0000300 7777666655554444333322221111000f 00000000000000000000000000000000
0 1 0 0000300 00000000000000000000000000000000 7777666655554444333322221111000f
